// ==== rtl/tracker_pkg.sv ====
/* Tag tracker shared definitions */

`default_nettype none

package tracker_pkg;

  // Tag pool size
  localparam int NUM_TAGS = 8;

  // Request lanes, completion lanes, alloc and dealloc ports
  localparam int NUM_LANES = 2;

  // Tag index width
  localparam int TAG_WIDTH = 3;

  // Request and completion payload width
  localparam int DATA_WIDTH = 16;

  // Holds 0 up to NUM_LANES deallocations per cycle
  localparam int COUNT_WIDTH = 2;

  typedef logic [TAG_WIDTH-1:0] tag_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Free-list offer slot
  typedef enum logic {
    SLOT_EMPTY,
    SLOT_OFFERED
  } slot_state_e;

  // Per-lane completion classification
  typedef enum logic [1:0] {
    CPL_NONE,
    CPL_RETIRE,
    CPL_BAD_TAG
  } cpl_outcome_e;

endpackage

`default_nettype wire

// ==== rtl/tracker_freelist.sv ====
/* Tag free list */

`timescale 1ns/1ns
`default_nettype none

module tracker_freelist import tracker_pkg::*; (
  input  logic                         clk,
  input  logic                         rst,
  // Allocation ports
  output logic [NUM_LANES-1:0]         alloc_valid,
  input  logic [NUM_LANES-1:0]         alloc_ready,
  output tag_t [NUM_LANES-1:0]         alloc_entry_id,
  // Deallocation ports
  input  logic [NUM_LANES-1:0]         dealloc_valid,
  input  tag_t [NUM_LANES-1:0]         dealloc_entry_id,
  output logic [COUNT_WIDTH-1:0]       dealloc_count
);

  // One bit per tag, set while the tag sits in the pool
  logic [NUM_TAGS-1:0] free_map;

  // Offer slots, one per alloc port
  slot_state_e slot_state [NUM_LANES];
  tag_t [NUM_LANES-1:0] slot_tag;

  // Pool after this cycle's picks
  logic [NUM_TAGS-1:0] avail;
  logic [NUM_TAGS-1:0] dealloc_mask;
  logic [NUM_LANES-1:0] slot_open;
  logic [NUM_LANES-1:0] pick_found;
  tag_t [NUM_LANES-1:0] pick_tag;
  logic [COUNT_WIDTH-1:0] dealloc_num;

  // Offers come straight from the slot registers
  always_comb begin
    for (int p = 0; p < NUM_LANES; p++) begin
      alloc_valid[p] = (slot_state[p] == SLOT_OFFERED);
    end
  end

  assign alloc_entry_id = slot_tag;

  // Refill selection
  // A held tag was taken out of free_map when loaded,
  // so the other slot's tag never shows up in avail
  always_comb begin
    avail = free_map;
    for (int p = 0; p < NUM_LANES; p++) begin
      // Empty slot, or its offer is being consumed this cycle
      slot_open[p] = (slot_state[p] == SLOT_EMPTY) || alloc_ready[p];
      pick_found[p] = 1'b0;
      pick_tag[p] = '0;
      if (slot_open[p]) begin
        // Scan downward so the lowest free tag wins
        for (int i = NUM_TAGS - 1; i >= 0; i--) begin
          if (avail[i]) begin
            pick_found[p] = 1'b1;
            pick_tag[p] = tag_t'(i);
          end
        end
        // Port 0 goes first, later ports see what is left
        if (pick_found[p]) begin
          avail[pick_tag[p]] = 1'b0;
        end
      end
    end
  end

  // Returned tags and their count
  always_comb begin
    dealloc_mask = '0;
    dealloc_num = '0;
    for (int d = 0; d < NUM_LANES; d++) begin
      if (dealloc_valid[d]) begin
        dealloc_mask[dealloc_entry_id[d]] = 1'b1;
        dealloc_num = dealloc_num + 1'b1;
      end
    end
  end

  // Pool, slot state and count
  always_ff @(posedge clk) begin
    if (rst) begin
      free_map <= '1;
      dealloc_count <= '0;
      for (int p = 0; p < NUM_LANES; p++) begin
        slot_state[p] <= SLOT_EMPTY;
      end
    end else begin
      // Returned tags become pickable from the next cycle on
      free_map <= avail | dealloc_mask;
      dealloc_count <= dealloc_num;
      for (int p = 0; p < NUM_LANES; p++) begin
        if (slot_open[p]) begin
          slot_state[p] <= pick_found[p] ? SLOT_OFFERED : SLOT_EMPTY;
        end
      end
    end
  end

  // Offered tag value, only meaningful while the slot is offered
  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_LANES; p++) begin
      if (slot_open[p] && pick_found[p]) begin
        slot_tag[p] <= pick_tag[p];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/request_intake.sv ====
/* Request intake */

`timescale 1ns/1ns
`default_nettype none

module request_intake import tracker_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  // External request lanes
  input  logic [NUM_LANES-1:0] req_valid,
  input  data_t [NUM_LANES-1:0] req_data,
  output logic [NUM_LANES-1:0] req_ready,
  // Free-list alloc ports
  input  logic [NUM_LANES-1:0] alloc_valid,
  input  tag_t [NUM_LANES-1:0] alloc_entry_id,
  output logic [NUM_LANES-1:0] alloc_ready,
  // Context table write
  output logic [NUM_LANES-1:0] ctx_wr_en,
  output tag_t [NUM_LANES-1:0] ctx_wr_tag,
  output data_t [NUM_LANES-1:0] ctx_wr_data,
  // Issued requests
  output logic [NUM_LANES-1:0] issue_valid,
  output tag_t [NUM_LANES-1:0] issue_tag,
  output data_t [NUM_LANES-1:0] issue_data
);

  // Lane accepts when a request meets an offered tag
  logic [NUM_LANES-1:0] accept;

  // A lane is ready only while its port offers a tag
  assign req_ready = alloc_valid;

  // Request valid doubles as the claim on the offer
  assign alloc_ready = req_valid;

  assign accept = req_valid & alloc_valid;

  // Store payload under the claimed tag at the accept edge
  assign ctx_wr_en = accept;
  assign ctx_wr_tag = alloc_entry_id;
  assign ctx_wr_data = req_data;

  // Issue pulse one cycle after acceptance
  always_ff @(posedge clk) begin
    if (rst) begin
      issue_valid <= '0;
      issue_tag <= '0;
      issue_data <= '0;
    end else begin
      issue_valid <= accept;
      for (int l = 0; l < NUM_LANES; l++) begin
        // Hold last issued values when the lane is idle
        if (accept[l]) begin
          issue_tag[l] <= alloc_entry_id[l];
          issue_data[l] <= req_data[l];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/context_table.sv ====
/* Tag context table */

`timescale 1ns/1ns
`default_nettype none

module context_table import tracker_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  // Write on issue
  input  logic [NUM_LANES-1:0]  wr_en,
  input  tag_t [NUM_LANES-1:0]  wr_tag,
  input  data_t [NUM_LANES-1:0] wr_data,
  // Lookup by completion tag
  input  tag_t [NUM_LANES-1:0]  rd_tag,
  output logic [NUM_LANES-1:0]  rd_live,
  output data_t [NUM_LANES-1:0] rd_data,
  // Clear on retire
  input  logic [NUM_LANES-1:0]  clr_en,
  input  tag_t [NUM_LANES-1:0]  clr_tag
);

  // Stored request payload per tag
  data_t payload [NUM_TAGS];

  // Set while the tag is outstanding
  logic [NUM_TAGS-1:0] live;

  // Live bits
  // A written tag was free and a cleared tag is live,
  // so the two never hit the same entry in one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      live <= '0;
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (clr_en[l]) begin
          live[clr_tag[l]] <= 1'b0;
        end
      end
      for (int l = 0; l < NUM_LANES; l++) begin
        if (wr_en[l]) begin
          live[wr_tag[l]] <= 1'b1;
        end
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (wr_en[l]) begin
        payload[wr_tag[l]] <= wr_data[l];
      end
    end
  end

  // Combinational lookup
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      rd_live[l] = live[rd_tag[l]];
      rd_data[l] = payload[rd_tag[l]];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/completion_retire.sv ====
/* Completion retire */

`timescale 1ns/1ns
`default_nettype none

module completion_retire import tracker_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  // Completion lanes
  input  logic [NUM_LANES-1:0]  cpl_valid,
  input  tag_t [NUM_LANES-1:0]  cpl_tag,
  input  data_t [NUM_LANES-1:0] cpl_data,
  // Context table lookup
  output tag_t [NUM_LANES-1:0]  rd_tag,
  input  logic [NUM_LANES-1:0]  rd_live,
  input  data_t [NUM_LANES-1:0] rd_data,
  // Context table clear
  output logic [NUM_LANES-1:0]  clr_en,
  output tag_t [NUM_LANES-1:0]  clr_tag,
  // Free-list dealloc ports
  output logic [NUM_LANES-1:0]  dealloc_valid,
  output tag_t [NUM_LANES-1:0]  dealloc_entry_id,
  // Responses and errors
  output logic [NUM_LANES-1:0]  resp_valid,
  output tag_t [NUM_LANES-1:0]  resp_tag,
  output data_t [NUM_LANES-1:0] resp_req_data,
  output data_t [NUM_LANES-1:0] resp_cpl_data,
  output logic [NUM_LANES-1:0]  cpl_error
);

  cpl_outcome_e outcome [NUM_LANES];

  // Tag already retired by a lower lane this cycle
  logic [NUM_LANES-1:0] dup_hit;
  logic [NUM_LANES-1:0] retire;
  logic [NUM_LANES-1:0] bad_tag;

  // Look up each lane's tag directly
  assign rd_tag = cpl_tag;

  // Classify lanes in order, lower lane wins on a shared tag
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      dup_hit[l] = 1'b0;
      for (int k = 0; k < l; k++) begin
        if (outcome[k] == CPL_RETIRE && cpl_tag[k] == cpl_tag[l]) begin
          dup_hit[l] = 1'b1;
        end
      end
      if (!cpl_valid[l]) begin
        outcome[l] = CPL_NONE;
      end else if (rd_live[l] && !dup_hit[l]) begin
        outcome[l] = CPL_RETIRE;
      end else begin
        outcome[l] = CPL_BAD_TAG;
      end
      retire[l] = (outcome[l] == CPL_RETIRE);
      bad_tag[l] = (outcome[l] == CPL_BAD_TAG);
    end
  end

  // Free the tag in the completion cycle
  assign clr_en = retire;
  assign clr_tag = cpl_tag;
  assign dealloc_valid = retire;
  assign dealloc_entry_id = cpl_tag;

  // Response and error pulses one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= '0;
      resp_tag <= '0;
      resp_req_data <= '0;
      resp_cpl_data <= '0;
      cpl_error <= '0;
    end else begin
      resp_valid <= retire;
      cpl_error <= bad_tag;
      for (int l = 0; l < NUM_LANES; l++) begin
        if (retire[l]) begin
          resp_tag[l] <= cpl_tag[l];
          resp_req_data[l] <= rd_data[l];
          resp_cpl_data[l] <= cpl_data[l];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tag_tracker_top.sv ====
/* Tag tracker top */

`timescale 1ns/1ns
`default_nettype none

module tag_tracker_top import tracker_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  // Request lanes
  input  logic [NUM_LANES-1:0]   req_valid,
  input  data_t [NUM_LANES-1:0]  req_data,
  output logic [NUM_LANES-1:0]   req_ready,
  // Issued requests
  output logic [NUM_LANES-1:0]   issue_valid,
  output tag_t [NUM_LANES-1:0]   issue_tag,
  output data_t [NUM_LANES-1:0]  issue_data,
  // Completion lanes
  input  logic [NUM_LANES-1:0]   cpl_valid,
  input  tag_t [NUM_LANES-1:0]   cpl_tag,
  input  data_t [NUM_LANES-1:0]  cpl_data,
  // Responses and errors
  output logic [NUM_LANES-1:0]   resp_valid,
  output tag_t [NUM_LANES-1:0]   resp_tag,
  output data_t [NUM_LANES-1:0]  resp_req_data,
  output data_t [NUM_LANES-1:0]  resp_cpl_data,
  output logic [NUM_LANES-1:0]   cpl_error,
  output logic [COUNT_WIDTH-1:0] dealloc_count
);

  // Intake to free list
  logic [NUM_LANES-1:0] alloc_valid;
  logic [NUM_LANES-1:0] alloc_ready;
  tag_t [NUM_LANES-1:0] alloc_entry_id;

  // Intake to context table
  logic [NUM_LANES-1:0] ctx_wr_en;
  tag_t [NUM_LANES-1:0] ctx_wr_tag;
  data_t [NUM_LANES-1:0] ctx_wr_data;

  // Retire to context table
  tag_t [NUM_LANES-1:0] rd_tag;
  logic [NUM_LANES-1:0] rd_live;
  data_t [NUM_LANES-1:0] rd_data;
  logic [NUM_LANES-1:0] clr_en;
  tag_t [NUM_LANES-1:0] clr_tag;

  // Retire to free list
  logic [NUM_LANES-1:0] dealloc_valid;
  tag_t [NUM_LANES-1:0] dealloc_entry_id;

  request_intake u_intake (
    .clk            (clk),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_data       (req_data),
    .req_ready      (req_ready),
    .alloc_valid    (alloc_valid),
    .alloc_entry_id (alloc_entry_id),
    .alloc_ready    (alloc_ready),
    .ctx_wr_en      (ctx_wr_en),
    .ctx_wr_tag     (ctx_wr_tag),
    .ctx_wr_data    (ctx_wr_data),
    .issue_valid    (issue_valid),
    .issue_tag      (issue_tag),
    .issue_data     (issue_data)
  );

  tracker_freelist u_freelist (
    .clk              (clk),
    .rst              (rst),
    .alloc_valid      (alloc_valid),
    .alloc_ready      (alloc_ready),
    .alloc_entry_id   (alloc_entry_id),
    .dealloc_valid    (dealloc_valid),
    .dealloc_entry_id (dealloc_entry_id),
    .dealloc_count    (dealloc_count)
  );

  context_table u_ctx (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (ctx_wr_en),
    .wr_tag  (ctx_wr_tag),
    .wr_data (ctx_wr_data),
    .rd_tag  (rd_tag),
    .rd_live (rd_live),
    .rd_data (rd_data),
    .clr_en  (clr_en),
    .clr_tag (clr_tag)
  );

  completion_retire u_retire (
    .clk              (clk),
    .rst              (rst),
    .cpl_valid        (cpl_valid),
    .cpl_tag          (cpl_tag),
    .cpl_data         (cpl_data),
    .rd_tag           (rd_tag),
    .rd_live          (rd_live),
    .rd_data          (rd_data),
    .clr_en           (clr_en),
    .clr_tag          (clr_tag),
    .dealloc_valid    (dealloc_valid),
    .dealloc_entry_id (dealloc_entry_id),
    .resp_valid       (resp_valid),
    .resp_tag         (resp_tag),
    .resp_req_data    (resp_req_data),
    .resp_cpl_data    (resp_cpl_data),
    .cpl_error        (cpl_error)
  );

endmodule

`default_nettype wire

// ==== verification/tag_tracker_assertions.sv ====
/* Free-list interface checks */

`timescale 1ns/1ns
`default_nettype none

module tag_tracker_assertions import tracker_pkg::*; (
  input logic                   clk,
  input logic                   rst,
  input logic [NUM_LANES-1:0]   alloc_valid,
  input logic [NUM_LANES-1:0]   alloc_ready,
  input tag_t [NUM_LANES-1:0]   alloc_entry_id,
  input logic [NUM_LANES-1:0]   dealloc_valid,
  input tag_t [NUM_LANES-1:0]   dealloc_entry_id,
  input logic [COUNT_WIDTH-1:0] dealloc_count
);

  // Read by the testbench to notice a fired check
  int unsigned fail_count = 0;

  // Tags handed out and not yet returned
  logic [NUM_TAGS-1:0] out_map;
  slot_state_e offer [NUM_LANES];

  always_comb begin
    for (int p = 0; p < NUM_LANES; p++) begin
      offer[p] = alloc_valid[p] ? SLOT_OFFERED : SLOT_EMPTY;
    end
  end

  // Returns clear first, then claims set
  always_ff @(posedge clk) begin
    if (rst) begin
      out_map <= '0;
    end else begin
      for (int p = 0; p < NUM_LANES; p++) begin
        if (dealloc_valid[p]) begin
          out_map[dealloc_entry_id[p]] <= 1'b0;
        end
      end
      for (int p = 0; p < NUM_LANES; p++) begin
        if (alloc_valid[p] && alloc_ready[p]) begin
          out_map[alloc_entry_id[p]] <= 1'b1;
        end
      end
    end
  end

  for (genvar p = 0; p < NUM_LANES; p++) begin : g_port
    // Offer held under back-pressure
    a_stable_offer: assert property (@(posedge clk) disable iff (rst)
      offer[p] == SLOT_OFFERED && !alloc_ready[p] |=>
        offer[p] == SLOT_OFFERED && $stable(alloc_entry_id[p]))
      else begin
        $error("offer on port %0d changed under back-pressure", p);
        fail_count++;
      end

    a_no_live_offer: assert property (@(posedge clk) disable iff (rst)
      offer[p] == SLOT_OFFERED |-> !out_map[alloc_entry_id[p]])
      else begin
        $error("port %0d offers a tag that is still outstanding", p);
        fail_count++;
      end
  end

  a_distinct_offers: assert property (@(posedge clk) disable iff (rst)
    offer[0] == SLOT_OFFERED && offer[1] == SLOT_OFFERED |->
      alloc_entry_id[0] != alloc_entry_id[1])
    else begin
      $error("both ports offer the same tag");
      fail_count++;
    end

  // Count lags the returns by one cycle
  a_dealloc_count: assert property (@(posedge clk) disable iff (rst)
    1'b1 |=> dealloc_count == $past($countones(dealloc_valid)))
    else begin
      $error("dealloc_count does not match last cycle's returns");
      fail_count++;
    end

endmodule

bind tracker_freelist tag_tracker_assertions u_fl_checks (
  .clk              (clk),
  .rst              (rst),
  .alloc_valid      (alloc_valid),
  .alloc_ready      (alloc_ready),
  .alloc_entry_id   (alloc_entry_id),
  .dealloc_valid    (dealloc_valid),
  .dealloc_entry_id (dealloc_entry_id),
  .dealloc_count    (dealloc_count)
);

`default_nettype wire

// ==== verification/tag_tracker_tb.sv ====
/* Tag tracker testbench */

`timescale 1ns/1ns
`default_nettype none

module tag_tracker_tb import tracker_pkg::*; ();

  localparam int NUM_ROWS = 20;
  localparam int BAD = -1;
  localparam int WAIT_BOUND = 6;
  localparam int CYCLE_LIMIT = 10 * NUM_ROWS + 100;
  localparam logic [15:0] LFSR_SEED = 16'd62050;

  // Lane 0 is bit 0; refs index issued requests in acceptance order
  typedef struct packed {
    logic [NUM_LANES-1:0] req_en;
    logic [NUM_LANES-1:0] cpl_en;
    int                   ref0;
    int                   ref1;
  } row_t;

  localparam row_t STIM_ROWS [NUM_ROWS] = '{
    '{2'b11, 2'b00, 0, 0},  '{2'b11, 2'b00, 0, 0},  '{2'b01, 2'b00, 0, 0},
    '{2'b10, 2'b00, 0, 0},  '{2'b11, 2'b00, 0, 0},
    // Pool full, both lanes stall
    '{2'b11, 2'b00, 0, 0},
    '{2'b00, 2'b01, 0, 0},  '{2'b01, 2'b00, 0, 0},  '{2'b00, 2'b11, 1, 2},
    // Bad tag, duplicate tag, already retired tag
    '{2'b00, 2'b10, 0, BAD}, '{2'b00, 2'b11, 3, 3}, '{2'b00, 2'b01, 1, 0},
    // Mixed traffic
    '{2'b11, 2'b11, 4, 5},  '{2'b11, 2'b11, 6, BAD}, '{2'b10, 2'b01, 7, 0},
    '{2'b00, 2'b11, 8, 9},  '{2'b11, 2'b11, 10, 11}, '{2'b00, 2'b11, 12, 13},
    '{2'b11, 2'b11, 14, BAD}, '{2'b00, 2'b11, 15, 16}
  };

  logic clk;
  logic rst;
  logic [NUM_LANES-1:0] req_valid;
  data_t [NUM_LANES-1:0] req_data;
  logic [NUM_LANES-1:0] req_ready;
  logic [NUM_LANES-1:0] issue_valid;
  tag_t [NUM_LANES-1:0] issue_tag;
  data_t [NUM_LANES-1:0] issue_data;
  logic [NUM_LANES-1:0] cpl_valid;
  tag_t [NUM_LANES-1:0] cpl_tag;
  data_t [NUM_LANES-1:0] cpl_data;
  logic [NUM_LANES-1:0] resp_valid;
  tag_t [NUM_LANES-1:0] resp_tag;
  data_t [NUM_LANES-1:0] resp_req_data;
  data_t [NUM_LANES-1:0] resp_cpl_data;
  logic [NUM_LANES-1:0] cpl_error;
  logic [COUNT_WIDTH-1:0] dealloc_count;

  // Reference model
  logic [NUM_TAGS-1:0] model_live;
  logic [NUM_TAGS-1:0] retired_once;
  data_t model_payload [NUM_TAGS];
  tag_t issued_tags [$];
  int held;

  // Outputs expected in the next cycle
  logic [NUM_LANES-1:0] exp_issue_valid;
  data_t [NUM_LANES-1:0] exp_issue_data;
  logic [NUM_LANES-1:0] exp_resp_valid;
  tag_t [NUM_LANES-1:0] exp_resp_tag;
  data_t [NUM_LANES-1:0] exp_resp_req_data;
  data_t [NUM_LANES-1:0] exp_resp_cpl_data;
  logic [NUM_LANES-1:0] exp_error;
  int exp_count;
  logic [NUM_LANES-1:0] seen_ready;

  logic [15:0] lfsr_state;
  int cycle_count = 0;
  int error_count = 0;
  int stall_lanes = 0;
  int wait_cycles = 0;
  int reuse_count = 0;

  tag_tracker_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $fatal(1, "run stopped on timeout");
    end
  end

  task automatic stop_run();
    error_count++;
    $display("Simulation FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic report_problem(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    stop_run();
  endtask

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic data_t rand_payload();
    data_t w;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      w[i] = lfsr_bit();
    end
    return w;
  endfunction

  // Request index to its issued tag, or a tag known not to be live
  task automatic resolve_ref(input int ref_idx, output tag_t t);
    int found;
    found = 0;
    t = '0;
    if (ref_idx == BAD) begin
      for (int i = NUM_TAGS - 1; i >= 0; i--) begin
        if (!model_live[i]) begin
          t = tag_t'(i);
          found = 1;
        end
      end
      assert (found == 1) else report_problem("no non-live tag left for a bad-tag completion");
    end else begin
      assert (ref_idx < issued_tags.size())
        else report_problem("row refers to an unissued request");
      t = issued_tags[ref_idx];
    end
  endtask

  // One cycle: check last cycle's effects at negedge, then model this cycle
  task automatic step();
    int n_ret;
    tag_t t;
    cpl_outcome_e outcome;
    @(negedge clk);
    assert (u_dut.u_freelist.u_fl_checks.fail_count == 0)
      else report_problem("a free-list assertion fired");
    assert (issue_valid == exp_issue_valid) else report_mismatch("issue_valid");
    for (int l = 0; l < NUM_LANES; l++) begin
      if (exp_issue_valid[l]) begin
        assert (issue_data[l] == exp_issue_data[l])
          else report_mismatch($sformatf("issue_data lane %0d", l));
        assert (!model_live[issue_tag[l]])
          else report_mismatch($sformatf("lane %0d issued live tag %0d", l, issue_tag[l]));
        if (retired_once[issue_tag[l]]) begin
          reuse_count++;
        end
        model_live[issue_tag[l]] = 1'b1;
        model_payload[issue_tag[l]] = exp_issue_data[l];
        issued_tags.push_back(issue_tag[l]);
      end
    end
    assert (resp_valid == exp_resp_valid) else report_mismatch("resp_valid");
    for (int l = 0; l < NUM_LANES; l++) begin
      if (exp_resp_valid[l]) begin
        assert (resp_tag[l] == exp_resp_tag[l] && resp_req_data[l] == exp_resp_req_data[l] &&
                resp_cpl_data[l] == exp_resp_cpl_data[l])
          else report_mismatch($sformatf("response contents lane %0d", l));
      end
    end
    assert (cpl_error == exp_error) else report_mismatch("cpl_error");
    assert (dealloc_count == exp_count) else report_mismatch("dealloc_count");
    // No free tag, so no lane may be ready
    if (held == NUM_TAGS) begin
      assert (req_ready == '0) else report_mismatch("req_ready high with every tag live");
    end
    seen_ready = req_ready;
    exp_issue_valid = req_valid & req_ready;
    exp_issue_data = req_data;
    held += $countones(exp_issue_valid);
    // Lanes in order, so lane 1 sees lane 0's retire
    n_ret = 0;
    exp_resp_valid = '0;
    exp_error = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      t = cpl_tag[l];
      if (!cpl_valid[l]) begin
        outcome = CPL_NONE;
      end else if (model_live[t]) begin
        outcome = CPL_RETIRE;
      end else begin
        outcome = CPL_BAD_TAG;
      end
      if (outcome == CPL_RETIRE) begin
        exp_resp_valid[l] = 1'b1;
        exp_resp_tag[l] = t;
        exp_resp_req_data[l] = model_payload[t];
        exp_resp_cpl_data[l] = cpl_data[l];
        model_live[t] = 1'b0;
        retired_once[t] = 1'b1;
        held--;
        n_ret++;
      end
      exp_error[l] = (outcome == CPL_BAD_TAG);
    end
    exp_count = n_ret;
    @(posedge clk);
    #1;
  endtask

  initial begin
    int waits;
    logic [NUM_LANES-1:0] pending;
    tag_t t;
    rst = 1'b1;
    req_valid = '0;
    req_data = '0;
    cpl_valid = '0;
    cpl_tag = '0;
    cpl_data = '0;
    lfsr_state = LFSR_SEED;
    model_live = '0;
    retired_once = '0;
    held = 0;
    exp_issue_valid = '0;
    exp_resp_valid = '0;
    exp_error = '0;
    exp_count = 0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    assert (req_ready == '0 && issue_valid == '0 && resp_valid == '0 && cpl_error == '0 &&
            dealloc_count == '0)
      else report_mismatch("outputs not idle after reset");
    @(posedge clk);
    #1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      pending = STIM_ROWS[r].req_en;
      req_valid = pending;
      for (int l = 0; l < NUM_LANES; l++) begin
        req_data[l] = rand_payload();
      end
      cpl_valid = STIM_ROWS[r].cpl_en;
      for (int l = 0; l < NUM_LANES; l++) begin
        if (STIM_ROWS[r].cpl_en[l]) begin
          resolve_ref((l == 0) ? STIM_ROWS[r].ref0 : STIM_ROWS[r].ref1, t);
          cpl_tag[l] = t;
          cpl_data[l] = rand_payload();
        end
      end
      // Completions last one cycle, requests wait for a ready lane
      waits = 0;
      do begin
        step();
        waits++;
        cpl_valid = '0;
        pending = pending & ~exp_issue_valid;
        req_valid = pending;
      end while (pending != '0 && waits < WAIT_BOUND);
      wait_cycles += waits - 1;
      if (pending != '0) begin
        stall_lanes += $countones(pending);
        assert (NUM_TAGS - held == $countones(seen_ready))
          else report_problem("request stalled although a free tag was not on offer");
      end
      // Drain cycle records issued tags before the next row
      step();
    end
    // Free-list checks at the last edges
    assert (u_dut.u_freelist.u_fl_checks.fail_count == 0)
      else report_problem("a free-list assertion fired");
    assert (stall_lanes > 0) else report_problem("tag pool never ran full");
    assert (reuse_count > 0) else report_problem("no retired tag was issued again");
    $display("Rows %0d, wait cycles %0d, stalled lanes %0d", NUM_ROWS, wait_cycles, stall_lanes);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/tracker_pkg.sv
rtl/tracker_freelist.sv
rtl/request_intake.sv
rtl/context_table.sv
rtl/completion_retire.sv
rtl/tag_tracker_top.sv
verification/tag_tracker_assertions.sv
verification/tag_tracker_tb.sv
